/* build.f */
+incdir+tb
logic/masku_pkg.sv
logic/masku_alu.sv
logic/masku_insn_ctrl.sv
logic/masku_result_queue.sv
logic/masku_scalar_acc.sv
logic/masku_top.sv
tb/masku_tb.sv

/* logic/masku_alu.sv */
// Combinational mask ALU; element order is flat across lanes, no byte shuffle
`timescale 1ns/1ps

module masku_alu import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  masku_req_t                                  insn_i,
  input  logic [VlWidth-1:0]                          remaining_i,
  input  masku_operand_t [NrLanes-1:0]                operand_i,
  output elen_t [NrLanes-1:0]                         wdata_o,
  output strb_t [NrLanes-1:0]                         be_o,
  output logic [NrLanes-1:0][$clog2(ElenWidth):0]     popcount_o
);

  localparam int unsigned BeatBits = NrLanes * ElenWidth;
  localparam int unsigned PopWidth = $clog2(ElenWidth) + 1;

  // Body bits lie below vl, enabled bits also pass the mask
  logic [BeatBits-1:0] body;
  elen_t [NrLanes-1:0] enable;

  ////////////////////////////////////////////////////////////////////////////
  // Body enable
  ////////////////////////////////////////////////////////////////////////////

  // remaining_i is vl minus the first element of this beat
  always_comb begin
    body = '1;
    if (remaining_i < VlWidth'(BeatBits)) begin
      body = ~({BeatBits{1'b1}} << remaining_i);
    end
  end

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      enable[l] = body[l*ElenWidth +: ElenWidth];
      // Masked instructions also need the element's m bit
      if (!insn_i.vm) begin
        enable[l] = enable[l] & operand_i[l].m;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merge, byte enables and population count
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      // Disabled bits keep the old destination value
      wdata_o[l] = (operand_i[l].a & enable[l]) | (operand_i[l].b & ~enable[l]);
      // A byte is written when any of its elements is in the body
      for (int by = 0; by < ElenBytes; by++) begin
        be_o[l][by] = |body[l*ElenWidth + by*8 +: 8];
      end
    end
  end

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      popcount_o[l] = '0;
      for (int i = 0; i < ElenWidth; i++) begin
        popcount_o[l] = popcount_o[l] +
                        PopWidth'(operand_i[l].b[i] & enable[l][i]);
      end
    end
  end

endmodule

/* logic/masku_insn_ctrl.sv */
// Single-entry instruction holder; a new request is taken only after done of the previous one
`timescale 1ns/1ps

module masku_insn_ctrl import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  masku_req_t                   req_i,
  input  logic                         req_valid_i,
  input  masku_operand_t [NrLanes-1:0] operand_i,
  input  logic                         queue_full_i,
  input  logic                         queue_empty_i,
  input  logic                         scalar_taken_i,
  output logic                         req_ready_o,
  output masku_req_t                   insn_o,
  output logic                         insn_valid_o,
  output logic [VlWidth-1:0]           remaining_o,
  output logic [AddrWidth-1:0]         beat_o,
  output logic                         beat_fire_o,
  output logic                         last_beat_o,
  output logic [NrLanes-1:0]           operand_ready_o,
  output logic                         done_o,
  output logic [VidWidth-1:0]          done_id_o
);

  // Element bits covered by one beat across all lanes
  localparam int unsigned BeatBits = NrLanes * ElenWidth;

  masku_req_t           insn_q;
  logic                 insn_valid_q;
  logic                 beats_done_q;
  logic [VlWidth-1:0]   remaining_q;
  logic [AddrWidth-1:0] beat_q;
  logic [NrLanes-1:0]   lane_valid;
  logic                 accept;

  ////////////////////////////////////////////////////////////////////////////
  // Beat handshake
  ////////////////////////////////////////////////////////////////////////////

  // b is needed by both ops, a only by merge, m only when masked
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      lane_valid[l] = operand_i[l].b_valid &&
                      (insn_q.op == OP_CPOP || operand_i[l].a_valid) &&
                      (insn_q.vm || operand_i[l].m_valid);
    end
  end

  // Merge beats also need a free queue slot
  assign beat_fire_o = insn_valid_q && !beats_done_q && (&lane_valid) &&
                       (insn_q.op == OP_CPOP || !queue_full_i);
  assign operand_ready_o = {NrLanes{beat_fire_o}};
  assign last_beat_o     = remaining_q <= VlWidth'(BeatBits);

  ////////////////////////////////////////////////////////////////////////////
  // Issue and completion
  ////////////////////////////////////////////////////////////////////////////

  assign req_ready_o = !insn_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  // Merge ends once the last entry has drained, cpop on the scalar handshake
  assign done_o = insn_valid_q &&
                  ((insn_q.op == OP_MERGE && beats_done_q && queue_empty_i) ||
                   (insn_q.op == OP_CPOP && scalar_taken_i));
  assign done_id_o = insn_q.id;

  assign insn_o       = insn_q;
  assign insn_valid_o = insn_valid_q;
  assign remaining_o  = remaining_q;
  assign beat_o       = beat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_q       <= '0;
      insn_valid_q <= 1'b0;
      beats_done_q <= 1'b0;
      remaining_q  <= '0;
      beat_q       <= '0;
    end else begin
      if (accept) begin
        insn_q       <= req_i;
        insn_valid_q <= 1'b1;
        beats_done_q <= 1'b0;
        remaining_q  <= req_i.vl;
        beat_q       <= '0;
      end else if (done_o) begin
        insn_valid_q <= 1'b0;
      end
      if (beat_fire_o) begin
        // Saturate so the tail beat leaves zero behind
        remaining_q  <= last_beat_o ? '0 : remaining_q - VlWidth'(BeatBits);
        beat_q       <= beat_q + 1'b1;
        beats_done_q <= last_beat_o;
      end
    end
  end

  // A scalar handshake only ever finishes a held cpop
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    scalar_taken_i |-> insn_valid_q && insn_q.op == OP_CPOP);

endmodule

/* logic/masku_pkg.sv */
// Shared widths and types of the mask unit; element bit i of a beat sits in lane i/64, bit i%64
package masku_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Lane datapath and its byte strobes
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned ElenBytes = ElenWidth / 8;
  // Vector length and remaining-bit counters
  localparam int unsigned VlWidth   = 16;
  localparam int unsigned VidWidth  = 3;
  // Register file word address
  localparam int unsigned AddrWidth = 8;
  // Scalar result toward the dispatcher
  localparam int unsigned XlenWidth = 32;

  typedef logic [ElenWidth-1:0] elen_t;
  typedef logic [ElenBytes-1:0] strb_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction and payload types
  ////////////////////////////////////////////////////////////////////////////

  // Mask-logical write-back or population count
  typedef enum logic {
    OP_MERGE = 1'b0,
    OP_CPOP  = 1'b1
  } masku_op_e;

  // Issue request from the sequencer
  typedef struct packed {
    masku_op_e              op;
    logic                   vm;
    logic [VlWidth-1:0]     vl;
    logic [AddrWidth-1:0]   vd_addr;
    logic [VidWidth-1:0]    id;
  } masku_req_t;

  // One result word toward a lane
  typedef struct packed {
    logic [VidWidth-1:0]  id;
    logic [AddrWidth-1:0] addr;
    elen_t                wdata;
    strb_t                be;
  } masku_result_t;

  // One lane's operand beat
  // a is the precomputed result, b the old destination, m the mask
  typedef struct packed {
    elen_t a;
    elen_t b;
    elen_t m;
    logic  a_valid;
    logic  b_valid;
    logic  m_valid;
  } masku_operand_t;

endpackage

/* logic/masku_result_queue.sv */
// Per-lane result queue; an entry pops only after every lane has granted it
`timescale 1ns/1ps

module masku_result_queue import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned Depth   = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  elen_t [NrLanes-1:0]               wdata_i,
  input  strb_t [NrLanes-1:0]               be_i,
  input  logic [AddrWidth-1:0]              addr_i,
  input  logic [VidWidth-1:0]               id_i,
  input  logic [NrLanes-1:0]                result_gnt_i,
  output logic                              full_o,
  output logic                              empty_o,
  output logic [NrLanes-1:0]                result_req_o,
  output logic [NrLanes-1:0][AddrWidth-1:0] result_addr_o,
  output logic [NrLanes-1:0][VidWidth-1:0]  result_id_o,
  output elen_t [NrLanes-1:0]               result_wdata_o,
  output strb_t [NrLanes-1:0]               result_be_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  masku_result_t [Depth-1:0][NrLanes-1:0] entry_q;
  logic [Depth-1:0][NrLanes-1:0]          valid_q;
  logic [PtrWidth-1:0]                    wr_ptr_q;
  logic [PtrWidth-1:0]                    rd_ptr_q;
  logic [PtrWidth:0]                      cnt_q;
  logic [NrLanes-1:0]                     head_left;
  logic                                   pop;

  assign full_o  = cnt_q == (PtrWidth+1)'(Depth);
  assign empty_o = cnt_q == '0;

  // Lanes still waiting for a grant after this cycle
  assign head_left = valid_q[rd_ptr_q] & ~result_gnt_i;
  assign pop       = !empty_o && (head_left == '0);

  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_req_o[l]   = valid_q[rd_ptr_q][l];
      result_addr_o[l]  = entry_q[rd_ptr_q][l].addr;
      result_id_o[l]    = entry_q[rd_ptr_q][l].id;
      result_wdata_o[l] = entry_q[rd_ptr_q][l].wdata;
      result_be_o[l]    = entry_q[rd_ptr_q][l].be;
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      for (int l = 0; l < NrLanes; l++) begin
        entry_q[wr_ptr_q][l] <= '{id: id_i, addr: addr_i, wdata: wdata_i[l], be: be_i[l]};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Granted lanes drop their request
      valid_q[rd_ptr_q] <= head_left;
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PtrWidth+1)'(push_i) - (PtrWidth+1)'(pop);
    end
  end

  // The controller must hold merge beats while the queue is full
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

  // Lanes only grant a pending request
  for (genvar l = 0; l < NrLanes; l++) begin : gen_gnt_check
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_gnt_i[l] |-> result_req_o[l]);
  end

endmodule

/* logic/masku_scalar_acc.sv */
// Popcount accumulator; the scalar result is held until the dispatcher takes it
`timescale 1ns/1ps

module masku_scalar_acc import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    add_i,
  input  logic                                    last_i,
  input  logic [NrLanes-1:0][$clog2(ElenWidth):0] popcount_i,
  input  logic                                    scalar_ready_i,
  output logic [XlenWidth-1:0]                    scalar_o,
  output logic                                    scalar_valid_o,
  output logic                                    taken_o
);

  logic [XlenWidth-1:0] acc_q;
  logic [XlenWidth-1:0] sum;

  // Running total plus this beat's lane counts
  always_comb begin
    sum = acc_q;
    for (int l = 0; l < NrLanes; l++) begin
      sum = sum + XlenWidth'(popcount_i[l]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q          <= '0;
      scalar_o       <= '0;
      scalar_valid_o <= 1'b0;
      taken_o        <= 1'b0;
    end else begin
      // One-cycle pulse after the handshake
      taken_o <= scalar_valid_o && scalar_ready_i;
      if (scalar_valid_o && scalar_ready_i) begin
        scalar_o       <= '0;
        scalar_valid_o <= 1'b0;
      end
      if (add_i) begin
        if (last_i) begin
          // Final beat publishes the total and restarts the sum
          scalar_o       <= sum;
          scalar_valid_o <= 1'b1;
          acc_q          <= '0;
        end else begin
          acc_q <= sum;
        end
      end
    end
  end

  // Dispatcher back-pressure must not disturb the pending result
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    scalar_valid_o && !scalar_ready_i |=> scalar_valid_o && $stable(scalar_o));

endmodule

/* logic/masku_top.sv */
// Mask unit top; one instruction in flight, NrLanes must be a power of two
`timescale 1ns/1ps

module masku_top import masku_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Sequencer
  input  masku_req_t                           req_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  output logic                                 done_o,
  output logic [VidWidth-1:0]                  done_id_o,
  // Lane operands
  input  masku_operand_t [NrLanes-1:0]         operand_i,
  output logic [NrLanes-1:0]                   operand_ready_o,
  // Lane register file writes
  output logic [NrLanes-1:0]                   result_req_o,
  output logic [NrLanes-1:0][AddrWidth-1:0]    result_addr_o,
  output logic [NrLanes-1:0][VidWidth-1:0]     result_id_o,
  output elen_t [NrLanes-1:0]                  result_wdata_o,
  output strb_t [NrLanes-1:0]                  result_be_o,
  input  logic [NrLanes-1:0]                   result_gnt_i,
  // Dispatcher
  output logic [XlenWidth-1:0]                 scalar_o,
  output logic                                 scalar_valid_o,
  input  logic                                 scalar_ready_i
);

  localparam int unsigned PopWidth = $clog2(ElenWidth) + 1;

  masku_req_t                        insn;
  logic                              insn_valid;
  logic [VlWidth-1:0]                remaining;
  logic [AddrWidth-1:0]              beat;
  logic                              beat_fire;
  logic                              last_beat;
  logic                              queue_full;
  logic                              queue_empty;
  logic                              scalar_taken;
  elen_t [NrLanes-1:0]               wdata;
  strb_t [NrLanes-1:0]               be;
  logic [NrLanes-1:0][PopWidth-1:0]  popcount;
  logic                              merge_push;
  logic                              cpop_add;
  logic [AddrWidth-1:0]              beat_addr;

  // Steer a consumed beat to the queue or the accumulator
  assign merge_push = beat_fire && insn_valid && (insn.op == OP_MERGE);
  assign cpop_add   = beat_fire && insn_valid && (insn.op == OP_CPOP);
  // Beat k writes register word vd + k
  assign beat_addr  = insn.vd_addr + beat;

  masku_insn_ctrl #(
    .NrLanes (NrLanes)
  ) i_insn_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .operand_i       (operand_i),
    .queue_full_i    (queue_full),
    .queue_empty_i   (queue_empty),
    .scalar_taken_i  (scalar_taken),
    .req_ready_o     (req_ready_o),
    .insn_o          (insn),
    .insn_valid_o    (insn_valid),
    .remaining_o     (remaining),
    .beat_o          (beat),
    .beat_fire_o     (beat_fire),
    .last_beat_o     (last_beat),
    .operand_ready_o (operand_ready_o),
    .done_o          (done_o),
    .done_id_o       (done_id_o)
  );

  masku_alu #(
    .NrLanes (NrLanes)
  ) i_alu (
    .insn_i      (insn),
    .remaining_i (remaining),
    .operand_i   (operand_i),
    .wdata_o     (wdata),
    .be_o        (be),
    .popcount_o  (popcount)
  );

  masku_result_queue #(
    .NrLanes (NrLanes),
    .Depth   (2)
  ) i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (merge_push),
    .wdata_i        (wdata),
    .be_i           (be),
    .addr_i         (beat_addr),
    .id_i           (insn.id),
    .result_gnt_i   (result_gnt_i),
    .full_o         (queue_full),
    .empty_o        (queue_empty),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o)
  );

  masku_scalar_acc #(
    .NrLanes (NrLanes)
  ) i_scalar_acc (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .add_i          (cpop_add),
    .last_i         (last_beat),
    .popcount_i     (popcount),
    .scalar_ready_i (scalar_ready_i),
    .scalar_o       (scalar_o),
    .scalar_valid_o (scalar_valid_o),
    .taken_o        (scalar_taken)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the mask unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module masku_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmasku_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* tb/masku_tests.svh */
// Directed tests and reference model; one instruction spans at most MaxBeats beats
`ifndef MASKU_TESTS_SVH
`define MASKU_TESTS_SVH

function automatic elen_t random_word();
  return {$random(seed), $random(seed)};
endfunction

// Expected words, strobes and cpop count straight from the element rules
task automatic build_model(input masku_req_t r);
  int   idx;
  logic en;
  exp_count = 0;
  for (int k = 0; k < exp_beats; k++) begin
    exp_addr[k] = r.vd_addr + AddrWidth'(k);
    for (int l = 0; l < NrLanes; l++) begin
      for (int i = 0; i < ElenWidth; i++) begin
        idx = k * BeatBits + l * ElenWidth + i;
        en  = (idx < int'(r.vl)) && (r.vm || beat_m[k][l*ElenWidth + i]);
        exp_wdata[k][l][i] = en ? beat_a[k][l*ElenWidth + i] : beat_b[k][l*ElenWidth + i];
        if (en && beat_b[k][l*ElenWidth + i]) begin
          exp_count++;
        end
      end
      // Byte written if its first element is in the body
      for (int by = 0; by < ElenBytes; by++) begin
        exp_be[k][l][by] = (k * BeatBits + l * ElenWidth + by * 8) < int'(r.vl);
      end
    end
  end
endtask

task automatic issue(input masku_req_t r);
  @(posedge clk_i);
  #2;
  req_i       = r;
  req_valid_i = 1'b1;
  @(negedge clk_i);
  while (!req_ready_o) @(negedge clk_i);
  @(posedge clk_i);
  #2;
  req_valid_i = 1'b0;
endtask

// Random beats, model, then the request
task automatic start_op(input masku_op_e kind, input logic vm, input int vl,
                        input logic [VidWidth-1:0] id, input logic [AddrWidth-1:0] vd);
  masku_req_t r;
  r = '{op: kind, vm: vm, vl: VlWidth'(vl), vd_addr: vd, id: id};
  exp_beats = (vl + BeatBits - 1) / BeatBits;
  for (int k = 0; k < exp_beats; k++) begin
    for (int l = 0; l < NrLanes; l++) begin
      beat_a[k][l*ElenWidth +: ElenWidth] = random_word();
      beat_b[k][l*ElenWidth +: ElenWidth] = random_word();
      beat_m[k][l*ElenWidth +: ElenWidth] = random_word();
    end
  end
  build_model(r);
  got_cnt   = '{default: 0};
  exp_id    = id;
  done_base = done_cnt;
  for (int k = 0; k < exp_beats; k++) begin
    a_q.push_back(beat_a[k]);
    b_q.push_back(beat_b[k]);
    m_q.push_back(beat_m[k]);
  end
  issue(r);
endtask

// A second pulse shortly after the first one counts as an error
task automatic wait_done();
  int n;
  n = 0;
  while (done_cnt == done_base && n < 200) begin
    @(posedge clk_i);
    n++;
  end
  if (done_cnt == done_base) begin
    errors++;
    $display("Timeout: done_o did not pulse within 200 cycles at %0t ns", $time);
  end else begin
    repeat (2) @(posedge clk_i);
    check(done_cnt - done_base, 1, "done pulse count");
    check(last_done_id, exp_id, "done id");
  end
endtask

task automatic finish_merge();
  wait_done();
  for (int l = 0; l < NrLanes; l++) begin
    check(got_cnt[l], exp_beats, $sformatf("lane %0d word count", l));
  end
endtask

// Scalar held for hold_cycles before the dispatcher takes it
task automatic finish_cpop(input int hold_cycles);
  int                   n;
  logic [XlenWidth-1:0] held;
  n = 0;
  @(negedge clk_i);
  while (!scalar_valid_o && n < 200) begin
    @(negedge clk_i);
    n++;
  end
  if (!scalar_valid_o) begin
    errors++;
    $display("Timeout: scalar_valid_o never rose at %0t ns", $time);
    return;
  end
  check(scalar_o, exp_count, "cpop result");
  held = scalar_o;
  repeat (hold_cycles) begin
    @(negedge clk_i);
    check(scalar_valid_o, 1, "scalar valid under back-pressure");
    check(scalar_o, held, "scalar value under back-pressure");
  end
  @(posedge clk_i);
  check(done_cnt, done_base, "done count before scalar handshake");
  #2;
  scalar_ready_i = 1'b1;
  @(posedge clk_i);
  #2;
  scalar_ready_i = 1'b0;
  wait_done();
  @(negedge clk_i);
  check(scalar_valid_o, 0, "scalar valid after handshake");
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic reset_values();
  @(negedge clk_i);
  check(req_ready_o, 1, "req_ready_o after reset");
  check(operand_ready_o, 0, "operand_ready_o after reset");
  check(result_req_o, 0, "result_req_o after reset");
  check(scalar_valid_o, 0, "scalar_valid_o after reset");
  check(done_o, 0, "done_o after reset");
endtask

task automatic unmasked_merge();
  start_op(OP_MERGE, 1'b1, 512, 3'd1, 8'h10);
  finish_merge();
endtask

task automatic tail_and_mask_merge();
  start_op(OP_MERGE, 1'b0, 100, 3'd2, 8'h20);
  finish_merge();
endtask

task automatic cpop_counts();
  start_op(OP_CPOP, 1'b1, 300, 3'd3, 8'h00);
  finish_cpop(0);
  start_op(OP_CPOP, 1'b0, 700, 3'd4, 8'h00);
  finish_cpop(5);
  start_op(OP_CPOP, 1'b0, 64, 3'd6, 8'h00);
  finish_cpop(3);
endtask

// Lane 2 withholds its grant until the queue has filled
task automatic grant_backpressure();
  elen_t held;
  @(posedge clk_i);
  #2;
  gnt_hold = 4'b0100;
  start_op(OP_MERGE, 1'b1, 1024, 3'd5, 8'h40);
  repeat (10) @(negedge clk_i);
  check(result_req_o[2], 1, "lane 2 request with grant held");
  check(operand_ready_o, 0, "operand_ready_o with full queue");
  held = result_wdata_o[2];
  repeat (4) begin
    @(negedge clk_i);
    check(result_req_o[2], 1, "lane 2 request still pending");
    check(result_wdata_o[2], held, "lane 2 data while pending");
    check(operand_ready_o, 0, "operand_ready_o while grant held");
  end
  @(posedge clk_i);
  check(done_cnt, done_base, "done count while grant held");
  #2;
  gnt_hold = '0;
  finish_merge();
endtask

`endif

/* tb/masku_tb.sv */
// Testbench of masku_top with 4 lanes; lanes grant at once unless held, beats are fed in order
`timescale 1ns/1ps

module masku_tb import masku_pkg::*; ();

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned BeatBits      = NrLanes * ElenWidth;
  localparam int unsigned MaxBeats      = 8;
  localparam int unsigned NumTests      = 7;
  localparam int unsigned TimeoutCycles = NumTests * 200 + 100;
  localparam time         ClkPeriod     = 20ns;

  typedef logic [BeatBits-1:0] beat_t;

  // DUT ports
  logic                              clk_i;
  logic                              rst_ni;
  masku_req_t                        req_i;
  logic                              req_valid_i;
  logic                              req_ready_o;
  logic                              done_o;
  logic [VidWidth-1:0]               done_id_o;
  masku_operand_t [NrLanes-1:0]      operand_i;
  logic [NrLanes-1:0]                operand_ready_o;
  logic [NrLanes-1:0]                result_req_o;
  logic [NrLanes-1:0][AddrWidth-1:0] result_addr_o;
  logic [NrLanes-1:0][VidWidth-1:0]  result_id_o;
  elen_t [NrLanes-1:0]               result_wdata_o;
  strb_t [NrLanes-1:0]               result_be_o;
  logic [NrLanes-1:0]                result_gnt_i;
  logic [XlenWidth-1:0]              scalar_o;
  logic                              scalar_valid_o;
  logic                              scalar_ready_i;

  // Stimulus state
  int                  seed = 32'h623d;
  beat_t               beat_a [MaxBeats];
  beat_t               beat_b [MaxBeats];
  beat_t               beat_m [MaxBeats];
  beat_t               a_q [$];
  beat_t               b_q [$];
  beat_t               m_q [$];
  logic                fire_seen = 1'b0;
  logic [NrLanes-1:0]  gnt_hold;

  // Expected results and bookkeeping
  elen_t                exp_wdata [MaxBeats][NrLanes];
  strb_t                exp_be [MaxBeats][NrLanes];
  logic [AddrWidth-1:0] exp_addr [MaxBeats];
  logic [VidWidth-1:0]  exp_id;
  int                   exp_beats;
  int                   exp_count;
  int                   got_cnt [NrLanes];
  int                   done_cnt = 0;
  int                   done_base;
  logic [VidWidth-1:0]  last_done_id;
  int                   errors = 0;
  int                   checks = 0;

  masku_top #(
    .NrLanes (NrLanes)
  ) uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Lanes grant every pending request unless held
  assign result_gnt_i = result_req_o & ~gnt_hold;

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // One granted word of lane l against the model
  task automatic check_write(input int l);
    int k;
    k = got_cnt[l];
    if (k >= exp_beats) begin
      errors++;
      $display("Lane %0d wrote more words than expected at %0t ns", l, $time);
    end else begin
      check(result_addr_o[l], exp_addr[k], $sformatf("lane %0d beat %0d address", l, k));
      check(result_id_o[l], exp_id, $sformatf("lane %0d beat %0d id", l, k));
      check(result_wdata_o[l], exp_wdata[k][l], $sformatf("lane %0d beat %0d data", l, k));
      check(result_be_o[l], exp_be[k][l], $sformatf("lane %0d beat %0d be", l, k));
    end
    got_cnt[l]++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Lane responders
  ////////////////////////////////////////////////////////////////////////////

  // Head beat stays on the lanes until a cycle with operand_ready_o high
  initial begin : operand_feeder
    operand_i = '0;
    forever begin
      @(posedge clk_i);
      #2;
      if (fire_seen && a_q.size() != 0) begin
        void'(a_q.pop_front());
        void'(b_q.pop_front());
        void'(m_q.pop_front());
      end
      operand_i = '0;
      if (a_q.size() != 0) begin
        for (int l = 0; l < NrLanes; l++) begin
          operand_i[l].a       = a_q[0][l*ElenWidth +: ElenWidth];
          operand_i[l].b       = b_q[0][l*ElenWidth +: ElenWidth];
          operand_i[l].m       = m_q[0][l*ElenWidth +: ElenWidth];
          operand_i[l].a_valid = 1'b1;
          operand_i[l].b_valid = 1'b1;
          operand_i[l].m_valid = 1'b1;
        end
      end
    end
  end

  // Outputs are stable mid-cycle
  always @(negedge clk_i) begin : result_monitor
    fire_seen = operand_ready_o[0];
    if (done_o) begin
      done_cnt++;
      last_done_id = done_id_o;
    end
    for (int l = 0; l < NrLanes; l++) begin
      if (result_req_o[l] && result_gnt_i[l]) begin
        check_write(l);
      end
    end
  end

  `include "masku_tests.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    rst_ni         = 1'b0;
    req_i          = '0;
    req_valid_i    = 1'b0;
    scalar_ready_i = 1'b0;
    gnt_hold       = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    reset_values();
    unmasked_merge();
    tail_and_mask_merge();
    cpop_counts();
    grant_backpressure();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(ClkPeriod * TimeoutCycles);
    $display("Watchdog expired: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule
